/* register_file.f */
+incdir+verilog
verilog/register_file_pkg.sv
verilog/register_bank.sv
verilog/register_file.sv
sim/register_file_props.sv
sim/register_file_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the register file testbench with Verilator and runs it.
# Exits with a failing status unless the run prints the pass message.

set -e

cd "$(dirname "$0")"

TOP=register_file_tb
OBJ_DIR=obj_dir

verilator --binary --timing --assert \
        -Wno-fatal \
        --top-module "${TOP}" \
        -Mdir "${OBJ_DIR}" \
        -f register_file.f

# A nonzero exit of the simulation, such as a failed assertion, stops here
output=$("./${OBJ_DIR}/V${TOP}")
echo "${output}"

if grep -qF -- "** PASS **" <<< "${output}"; then
        echo "Simulation passed"
        exit 0
else
        echo "Simulation failed"
        exit 1
fi

/* sim/register_file_props.sv */
// Concurrent assertions on the register file, bound into every instance.
// Signals are sampled at the rising edge, so inputs must settle before it.
// The write-then-read rule skips address 0, which never holds data.

`default_nettype none

module register_file_props import register_file_pkg::*; (
        input wire logic      clk_i,
        input wire logic      reset_i,
        input wire reg_addr_t rd_addr_i,
        input wire reg_data_t rd_data_i,
        input wire reg_addr_t rs1_addr_i,
        input wire reg_addr_t rs2_addr_i,
        input wire reg_addr_t rs3_addr_i,
        input wire reg_data_t rs1_data_i,
        input wire reg_data_t rs2_data_i,
        input wire reg_data_t rs3_data_i
);

        int fail_count = 0;     // Assertion failures so far

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Integer register 0

        a_rs1_zero: assert property (@(posedge clk_i) disable iff (reset_i)
                (rs1_addr_i == '0) |-> (rs1_data_i == '0))
                else begin
                        fail_count++;
                        $error("rs1 read of integer register 0 is not zero");
                end
        a_rs2_zero: assert property (@(posedge clk_i) disable iff (reset_i)
                (rs2_addr_i == '0) |-> (rs2_data_i == '0))
                else begin
                        fail_count++;
                        $error("rs2 read of integer register 0 is not zero");
                end
        a_rs3_zero: assert property (@(posedge clk_i) disable iff (reset_i)
                (rs3_addr_i == '0) |-> (rs3_data_i == '0))
                else begin
                        fail_count++;
                        $error("rs3 read of integer register 0 is not zero");
                end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Write visible one cycle later

        a_rs1_written: assert property (@(posedge clk_i)
                (!reset_i && rd_addr_i != '0) |=>
                (rs1_addr_i != $past(rd_addr_i) || rs1_data_i == $past(rd_data_i)))
                else begin
                        fail_count++;
                        $error("rs1 does not return the data written a cycle before");
                end
        a_rs2_written: assert property (@(posedge clk_i)
                (!reset_i && rd_addr_i != '0) |=>
                (rs2_addr_i != $past(rd_addr_i) || rs2_data_i == $past(rd_data_i)))
                else begin
                        fail_count++;
                        $error("rs2 does not return the data written a cycle before");
                end
        a_rs3_written: assert property (@(posedge clk_i)
                (!reset_i && rd_addr_i != '0) |=>
                (rs3_addr_i != $past(rd_addr_i) || rs3_data_i == $past(rd_data_i)))
                else begin
                        fail_count++;
                        $error("rs3 does not return the data written a cycle before");
                end

endmodule

bind register_file register_file_props u_props (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .rd_addr_i  (rd_addr_i),
        .rd_data_i  (rd_data_i),
        .rs1_addr_i (rs1_addr_i),
        .rs2_addr_i (rs2_addr_i),
        .rs3_addr_i (rs3_addr_i),
        .rs1_data_i (rs1_data_o),
        .rs2_data_i (rs2_data_o),
        .rs3_data_i (rs3_data_o)
);

`default_nettype wire

/* sim/register_file_tb.sv */
// Self-checking testbench for the RV32F operand register file.
// Inputs change 1 time unit after each rising edge. All three read ports
// are compared with a reference model just before the next edge.
// The model takes a write on every edge after reset, as the DUT does, and
// address 0 is forced to zero only when the model is read.

`default_nettype none

`include "register_file_defines.svh"

module register_file_tb import register_file_pkg::*; ();

        localparam int CLK_PERIOD    = 10;
        localparam int RESET_CYCLES  = 10;
        localparam int NUM_ADDRS     = 2 ** `RF_ADDR_W;
        localparam int RANDOM_CYCLES = 200;

        // Cycles driven by the sequence below, in the order they run
        localparam int TEST_CYCLES = NUM_ADDRS + 2 * (`RF_NUM_REGS - 1) + 2 + 4 + 2
                                     + RANDOM_CYCLES + 2;

        logic      clk;
        logic      reset;
        reg_addr_t rd_addr;
        reg_data_t rd_data;
        reg_addr_t rs1_addr;
        reg_addr_t rs2_addr;
        reg_addr_t rs3_addr;
        reg_data_t rs1_data;
        reg_data_t rs2_data;
        reg_data_t rs3_data;

        reg_data_t model [NUM_ADDRS];   // Register state after the latest edge
        int        error_count = 0;
        int        check_count = 0;
        integer    seed;

        register_file DUT (
                .clk_i      (clk),
                .reset_i    (reset),
                .rd_addr_i  (rd_addr),
                .rd_data_i  (rd_data),
                .rs1_addr_i (rs1_addr),
                .rs2_addr_i (rs2_addr),
                .rs3_addr_i (rs3_addr),
                .rs1_data_o (rs1_data),
                .rs2_data_o (rs2_data),
                .rs3_data_o (rs3_data)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Reference model

        always @(posedge clk) begin
                if (reset) begin
                        for (int i = 0; i < NUM_ADDRS; i++) begin
                                model[i] <= '0;
                        end
                end else begin
                        model[rd_addr] <= rd_data;      // No enable, every edge writes
                end
        end

        function automatic reg_data_t model_read(input reg_addr_t addr);
                if (addr == '0) begin
                        return '0;      // Integer register 0
                end else begin
                        return model[addr];
                end
        endfunction

        task automatic check_value(input string name, input reg_data_t actual,
                                   input reg_data_t expected);
                check_count++;
                if (actual !== expected) begin
                        $display("[ERROR] %0t: %s = 0x%h, expected 0x%h",
                                 $time, name, actual, expected);
                        error_count++;
                end
        endtask

        // Compare near the end of each cycle, when the read data has settled
        initial begin
                forever begin
                        @(posedge clk);
                        #(CLK_PERIOD - 2);
                        if (!reset) begin
                                check_value("rs1_data_o", rs1_data, model_read(rs1_addr));
                                check_value("rs2_data_o", rs2_data, model_read(rs2_addr));
                                check_value("rs3_data_o", rs3_data, model_read(rs3_addr));
                        end
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Stimulus

        task automatic drive_cycle(input reg_addr_t wr_addr, input reg_data_t wr_data,
                                   input reg_addr_t addr1, input reg_addr_t addr2,
                                   input reg_addr_t addr3);
                @(posedge clk);
                #1;
                rd_addr  = wr_addr;
                rd_data  = wr_data;
                rs1_addr = addr1;
                rs2_addr = addr2;
                rs3_addr = addr3;
        endtask

        initial begin
                seed     = 8;
                reset    = 1'b1;
                rd_addr  = '0;
                rd_data  = '0;
                rs1_addr = '0;
                rs2_addr = '0;
                rs3_addr = '0;
                repeat (RESET_CYCLES) @(posedge clk);
                #1;
                reset = 1'b0;

                // Every address reads zero after reset
                for (int a = 0; a < NUM_ADDRS; a++) begin
                        drive_cycle('0, '0, reg_addr_t'(a), reg_addr_t'(a + 21),
                                    reg_addr_t'(a + 42));
                end

                // Port 1 sees the old value in the write cycle, port 2 the new one after
                for (int i = 1; i < `RF_NUM_REGS; i++) begin
                        drive_cycle(reg_addr_t'(i), {8'hA5, 8'(i), 8'h3C, 8'(i)},
                                    reg_addr_t'(i), reg_addr_t'(i - 1), '0);
                end
                for (int i = 1; i < `RF_NUM_REGS; i++) begin
                        drive_cycle('0, '0, reg_addr_t'(i), reg_addr_t'(`RF_NUM_REGS - i),
                                    reg_addr_t'(i));
                end

                // Writes to integer register 0 are lost
                drive_cycle('0, 32'hDEAD_BEEF, '0, '0, '0);
                drive_cycle('0, '0, '0, '0, '0);

                // Float register 0 stores, and index 5 is separate in each bank
                drive_cycle(6'd32, 32'hF00D_CAFE, 6'd32, 6'd0, 6'd32);
                drive_cycle(6'd37, 32'h1234_5678, 6'd32, 6'd5, 6'd37);
                drive_cycle(6'd5, 32'h0BAD_F00D, 6'd37, 6'd5, 6'd32);
                drive_cycle('0, '0, 6'd5, 6'd37, 6'd32);

                // Mixed banks on the three ports at once
                drive_cycle('0, '0, 6'd3, 6'd37, 6'd32);
                drive_cycle('0, '0, 6'd40, 6'd7, 6'd0);

                for (int n = 0; n < RANDOM_CYCLES; n++) begin
                        drive_cycle(reg_addr_t'($random(seed)), reg_data_t'($random(seed)),
                                    reg_addr_t'($random(seed)), reg_addr_t'($random(seed)),
                                    reg_addr_t'($random(seed)));
                end

                drive_cycle('0, '0, '0, '0, '0);
                @(posedge clk);         // Last compare has run by now

                $display("Checks: %0d, errors: %0d, assertion failures: %0d",
                         check_count, error_count, DUT.u_props.fail_count);
                if (error_count == 0 && DUT.u_props.fail_count == 0) begin
                        $display("** PASS **");
                end else begin
                        $display("** FAIL **");
                end
                $finish;
        end

        initial begin
                #((RESET_CYCLES + TEST_CYCLES + 20) * CLK_PERIOD);
                $display("Timeout: the test sequence did not finish in time");
                $display("** FAIL **");
                $finish;
        end

endmodule

`default_nettype wire

/* verilog/register_bank.sv */
// One bank of RF_NUM_REGS registers.
// The write lands at the rising edge when wr_en_i is high, so a read of
// the same register in that cycle still sees the old word.
// Reads are combinational on all three ports.
// With HARDWIRED_ZERO set, register 0 has no storage and reads zero.

`default_nettype none

`include "register_file_defines.svh"

module register_bank import register_file_pkg::*; #(
        parameter bit HARDWIRED_ZERO = 1'b1
) (
        input  wire logic       clk_i,
        input  wire logic       reset_i,

        // Write port
        input  wire logic       wr_en_i,
        input  wire reg_index_t wr_index_i,
        input  wire reg_data_t  wr_data_i,

        // Read ports
        input  wire reg_index_t rs1_index_i,
        input  wire reg_index_t rs2_index_i,
        input  wire reg_index_t rs3_index_i,
        output reg_data_t       rs1_data_o,
        output reg_data_t       rs2_data_o,
        output reg_data_t       rs3_data_o
);

        // Current value of every register, stored or constant
        reg_data_t regs [`RF_NUM_REGS];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Storage

        for (genvar i = 0; i < `RF_NUM_REGS; i++) begin : g_reg
                if (HARDWIRED_ZERO && i == 0) begin : g_zero
                        assign regs[i] = '0;    // Writes to it go nowhere
                end else begin : g_store
                        logic      wr_hit;
                        reg_data_t q;

                        assign wr_hit = wr_en_i && (wr_index_i == reg_index_t'(i));

                        always_ff @(posedge clk_i) begin
                                if (reset_i) begin
                                        q <= '0;
                                end else if (wr_hit) begin
                                        q <= wr_data_i;
                                end
                        end

                        assign regs[i] = q;
                end
        end

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Read ports

        // No write bypass, a same-cycle read returns the value from before the edge
        assign rs1_data_o = regs[rs1_index_i];
        assign rs2_data_o = regs[rs2_index_i];
        assign rs3_data_o = regs[rs3_index_i];  // Third source for fused multiply-add

endmodule

`default_nettype wire

/* verilog/register_file.sv */
// Operand register file of an RV32F core, integer and float banks.
// There is no write enable: every rising edge writes rd_data_i to
// rd_addr_i, so an idle cycle must address integer register 0.
// Float register 0 is an ordinary register, integer register 0 reads zero.
// Reads are combinational and have no bypass from the write in flight.

`default_nettype none

`include "register_file_defines.svh"

module register_file import register_file_pkg::*; (
        input  wire logic      clk_i,
        input  wire logic      reset_i,

        // Writeback from the pipeline
        input  wire reg_addr_t rd_addr_i,
        input  wire reg_data_t rd_data_i,

        // Source operands
        input  wire reg_addr_t rs1_addr_i,
        input  wire reg_addr_t rs2_addr_i,
        input  wire reg_addr_t rs3_addr_i,
        output reg_data_t      rs1_data_o,
        output reg_data_t      rs2_data_o,
        output reg_data_t      rs3_data_o
);

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Address split

        logic       wr_fp;
        reg_index_t wr_index;
        reg_index_t rs1_index;
        reg_index_t rs2_index;
        reg_index_t rs3_index;

        assign wr_fp    = rd_addr_i[`RF_BANK_BIT];
        assign wr_index = rd_addr_i[`RF_INDEX_W-1:0];

        // Both banks see the same read indices and the top picks one result
        assign rs1_index = rs1_addr_i[`RF_INDEX_W-1:0];
        assign rs2_index = rs2_addr_i[`RF_INDEX_W-1:0];
        assign rs3_index = rs3_addr_i[`RF_INDEX_W-1:0];

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Banks

        reg_data_t int_rs1_data;
        reg_data_t int_rs2_data;
        reg_data_t int_rs3_data;
        reg_data_t fp_rs1_data;
        reg_data_t fp_rs2_data;
        reg_data_t fp_rs3_data;

        register_bank #(
                .HARDWIRED_ZERO (1'b1)
        ) u_int_bank (
                .clk_i       (clk_i),
                .reset_i     (reset_i),
                .wr_en_i     (!wr_fp),
                .wr_index_i  (wr_index),
                .wr_data_i   (rd_data_i),
                .rs1_index_i (rs1_index),
                .rs2_index_i (rs2_index),
                .rs3_index_i (rs3_index),
                .rs1_data_o  (int_rs1_data),
                .rs2_data_o  (int_rs2_data),
                .rs3_data_o  (int_rs3_data)
        );

        register_bank #(
                .HARDWIRED_ZERO (1'b0)
        ) u_fp_bank (
                .clk_i       (clk_i),
                .reset_i     (reset_i),
                .wr_en_i     (wr_fp),
                .wr_index_i  (wr_index),
                .wr_data_i   (rd_data_i),
                .rs1_index_i (rs1_index),
                .rs2_index_i (rs2_index),
                .rs3_index_i (rs3_index),
                .rs1_data_o  (fp_rs1_data),
                .rs2_data_o  (fp_rs2_data),
                .rs3_data_o  (fp_rs3_data)
        );

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Read select

        // Each port follows its own bank bit, so one instruction may mix banks
        assign rs1_data_o = rs1_addr_i[`RF_BANK_BIT] ? fp_rs1_data : int_rs1_data;
        assign rs2_data_o = rs2_addr_i[`RF_BANK_BIT] ? fp_rs2_data : int_rs2_data;
        assign rs3_data_o = rs3_addr_i[`RF_BANK_BIT] ? fp_rs3_data : int_rs3_data;

endmodule

`default_nettype wire

/* verilog/register_file_defines.svh */
// Sizing of the RV32F operand register file.
// RF_NUM_REGS must equal 2**RF_INDEX_W, since every in-bank index
// selects a stored word and the read ports do no range check.
// The bank-select bit sits directly above the index bits.

`ifndef REGISTER_FILE_DEFINES_SVH
`define REGISTER_FILE_DEFINES_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Data path

// Width of one register, integer or single-precision float
`define RF_XLEN 32

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Addressing

// Bits that name a register inside one bank
`define RF_INDEX_W 5

// Registers held by each bank
`define RF_NUM_REGS 32

// Full operand address, index plus the bank bit
`define RF_ADDR_W 6

// A one here names the floating-point bank, a zero the integer bank
`define RF_BANK_BIT 5

`endif

/* verilog/register_file_pkg.sv */
// Types shared by the register file and its testbench.
// All of them are plain vectors sized from the defines header.

`default_nettype none

`include "register_file_defines.svh"

package register_file_pkg;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Register contents

        // One stored word, read as integer or as a raw IEEE single
        typedef logic [`RF_XLEN-1:0] reg_data_t;

        // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
        // Register names

        // Operand address as the decoder produces it, bank bit on top
        typedef logic [`RF_ADDR_W-1:0] reg_addr_t;

        // Register number within one bank
        typedef logic [`RF_INDEX_W-1:0] reg_index_t;

endpackage

`default_nettype wire
